//--- st_bus_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// st bus glue types and constants
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package st_bus_pkg;

	// cpu word address, addr[23:1]
	localparam int addr_w = 23;

	// cpu slots without dtack before the core sees a bus error
	localparam logic [3:0] berr_limit = 4'd15;

	// ram size codes
	localparam logic [2:0] mem_512k = 3'd0;
	localparam logic [2:0] mem_1m   = 3'd1;
	localparam logic [2:0] mem_2m   = 3'd2;
	localparam logic [2:0] mem_4m   = 3'd3;
	localparam logic [2:0] mem_8m   = 3'd4;
	localparam logic [2:0] mem_14m  = 3'd5;

	// the st uses autovectors for hbi and vbi, supplied by the glue
	localparam logic [7:0] vec_vbi = 8'h1c;
	localparam logic [7:0] vec_hbi = 8'h1a;

	// ipl[0] is tied high on the st, so only levels 6, 4 and 2 exist
	localparam logic [2:0] ipl_mfp  = 3'b001;
	localparam logic [2:0] ipl_vbi  = 3'b011;
	localparam logic [2:0] ipl_hbi  = 3'b101;
	localparam logic [2:0] ipl_idle = 3'b111;

	// cpu space cycle
	localparam logic [2:0] fc_iack = 3'd7;

	// device windows inside page 0xff
	// offset bits from *_lsb upward are compared against the base
	localparam logic [15:0] io_mmu_base     = 16'h8000;
	localparam int          io_mmu_lsb      = 1;
	localparam logic [15:0] io_vreg_base    = 16'h8200;
	localparam int          io_vreg_lsb     = 7;
	localparam logic [15:0] io_dma_base     = 16'h8600;
	localparam int          io_dma_lsb      = 4;
	localparam logic [15:0] io_psg_base     = 16'h8800;
	localparam int          io_psg_lsb      = 8;
	localparam logic [15:0] io_acia_base    = 16'hfc00;
	localparam int          io_acia_lsb     = 8;
	localparam logic [15:0] io_mfp_base     = 16'hfa00;
	localparam int          io_mfp_lsb      = 6;
	localparam logic [15:0] io_blitter_base = 16'h8a00;
	localparam int          io_blitter_lsb  = 8;

	// iack cycles carry the level in byte address bits 3:1
	typedef struct packed {
		logic [addr_w-4:0] unused;
		logic [2:0]        level;
	} iack_view_t;

	typedef union packed {
		logic [addr_w-1:0] mem;
		iack_view_t        iack;
	} cpu_addr_u;

	// latched cpu request, valid is the address strobe
	typedef struct packed {
		logic       valid;
		logic       rw;
		logic       uds;
		logic       lds;
		logic [2:0] fc;
		cpu_addr_u  addr;
	} cpu_req_t;

	typedef struct packed {
		logic mmu;
		logic vreg;
		logic dma;
		logic psg;
		logic acia;
		logic mfp;
		logic blitter;
	} io_sel_t;

	// request after the memory map lookup
	typedef struct packed {
		logic       valid;
		logic       rw;
		logic       uds;
		logic       lds;
		logic [2:0] fc;
		cpu_addr_u  addr;
		logic       ram_hit;
		logic       rom_hit;
		io_sel_t    io;
		logic       iack;
		logic [2:0] iack_level;
	} dec_t;

	// interrupt acknowledge strobe towards the irq controller
	typedef struct packed {
		logic       ack;
		logic [2:0] level;
	} ack_t;

endpackage

//--- cpu_req_latch.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cpu request latch
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module cpu_req_latch import st_bus_pkg::*; (
	input  logic       clk_8,
	input  logic       pll_locked,
	input  logic       as,
	input  logic       rw,
	input  logic       uds,
	input  logic       lds,
	input  logic [2:0] fc,
	input  cpu_addr_u  addr,
	output cpu_req_t   req
);

	logic       as_q;
	logic       rw_q;
	logic       uds_q;
	logic       lds_q;
	logic [2:0] fc_q;
	cpu_addr_u  addr_q;

	// address strobe, the only control bit of the request
	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			as_q <= 1'b0;
		end else begin
			as_q <= as;
		end
	end

	// cpu outputs are frozen for a whole 8 MHz cycle
	// so a core stepping ahead cannot disturb the cycle in progress
	always_ff @(posedge clk_8) begin
		rw_q   <= rw;
		uds_q  <= uds;
		lds_q  <= lds;
		fc_q   <= fc;
		addr_q <= addr;
	end

	always_comb begin
		req.valid = as_q;
		req.rw    = rw_q;
		req.uds   = uds_q;
		req.lds   = lds_q;
		req.fc    = fc_q;
		req.addr  = addr_q;
	end

endmodule

//--- addr_decode.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// st memory and io map decode
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module addr_decode import st_bus_pkg::*; (
	input  logic       clk_8,
	input  logic       pll_locked,
	input  cpu_req_t   req,
	input  logic [2:0] mem_cfg,
	input  logic       blitter_en,
	output dec_t       dec
);

	logic [addr_w-1:0] a;
	logic [15:0]       offs;
	logic              io_page;
	logic              ram_8m;
	logic              ram_14m;
	logic              low_rom;
	logic              rom_any;
	logic              ram_area;
	logic              iack_d;
	logic              ram_d;
	logic              rom_d;
	io_sel_t           io_d;

	logic       valid_q;
	logic       ram_q;
	logic       rom_q;
	logic       iack_q;
	io_sel_t    io_q;
	logic       rw_q;
	logic       uds_q;
	logic       lds_q;
	logic [2:0] fc_q;
	cpu_addr_u  addr_q;
	logic [2:0] level_q;

	// true when the offset falls inside the window at base
	function automatic logic io_hit(input logic [15:0] off, input logic [15:0] base,
			input int lsb);
		io_hit = ((off ^ base) >> lsb) == 16'd0;
	endfunction

	// word address view, a[22:15] is byte address 23:16
	assign a       = req.addr.mem;
	assign offs    = {a[14:0], 1'b0};
	assign io_page = (a[22:15] == 8'hff);
	assign iack_d  = (req.fc == fc_iack);

	// everything up to 4 MB shares the base bank
	always_comb begin
		case (mem_cfg)
			mem_512k, mem_1m, mem_2m, mem_4m: begin
				ram_8m  = 1'b0;
				ram_14m = 1'b0;
			end
			mem_8m: begin
				ram_8m  = 1'b1;
				ram_14m = 1'b0;
			end
			mem_14m: begin
				ram_8m  = 1'b1;
				ram_14m = 1'b1;
			end
			default: begin
				ram_8m  = 1'b0;
				ram_14m = 1'b0;
			end
		endcase
	end

	// first 8 bytes mirror the rom reset vectors
	assign low_rom = (a[22:2] == 21'd0);

	// tos 256k at 0xe00000, tos 192k at 0xfc0000, cartridge at 0xfa/0xfb
	assign rom_any = low_rom
		|| (a[22:17] == 6'b111000)
		|| (a[22:16] == 7'b1111110)
		|| (a[22:15] == 8'hfe)
		|| (a[22:15] == 8'hfa)
		|| (a[22:15] == 8'hfb);

	assign ram_area = (a[22:21] == 2'b00)
		|| (ram_8m && (a[22:21] == 2'b01))
		|| (ram_14m && ((a[22:21] == 2'b10) || (a[22:20] == 3'b110)));

	// cpu space cycles never reach memory or a device
	always_comb begin
		ram_d = !iack_d && !low_rom && ram_area;
		// rom write hits nothing and ends in a bus error
		rom_d = !iack_d && req.rw && rom_any;
		io_d  = '0;
		if (io_page && !iack_d) begin
			io_d.mmu     = io_hit(offs, io_mmu_base, io_mmu_lsb);
			io_d.vreg    = io_hit(offs, io_vreg_base, io_vreg_lsb);
			io_d.dma     = io_hit(offs, io_dma_base, io_dma_lsb);
			io_d.psg     = io_hit(offs, io_psg_base, io_psg_lsb);
			io_d.acia    = io_hit(offs, io_acia_base, io_acia_lsb);
			io_d.mfp     = io_hit(offs, io_mfp_base, io_mfp_lsb);
			io_d.blitter = blitter_en && io_hit(offs, io_blitter_base, io_blitter_lsb);
		end
	end

	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			valid_q <= 1'b0;
			ram_q   <= 1'b0;
			rom_q   <= 1'b0;
			iack_q  <= 1'b0;
			io_q    <= '0;
		end else begin
			valid_q <= req.valid;
			ram_q   <= ram_d;
			rom_q   <= rom_d;
			iack_q  <= iack_d;
			io_q    <= io_d;
		end
	end

	// request payload follows along, level taken from the iack view
	always_ff @(posedge clk_8) begin
		rw_q    <= req.rw;
		uds_q   <= req.uds;
		lds_q   <= req.lds;
		fc_q    <= req.fc;
		addr_q  <= req.addr;
		level_q <= iack_d ? req.addr.iack.level : 3'd0;
	end

	always_comb begin
		dec.valid      = valid_q;
		dec.rw         = rw_q;
		dec.uds        = uds_q;
		dec.lds        = lds_q;
		dec.fc         = fc_q;
		dec.addr       = addr_q;
		dec.ram_hit    = ram_q;
		dec.rom_hit    = rom_q;
		dec.io         = io_q;
		dec.iack       = iack_q;
		dec.iack_level = level_q;
	end

	// device windows in page 0xff must never overlap
	a_io_onehot: assert property (@(posedge clk_8) disable iff (!pll_locked)
		$onehot0(dec.io))
		else $error("addr_decode: more than one io select");

endmodule

//--- bus_slot_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus slot arbitration and dtack
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module bus_slot_ctrl import st_bus_pkg::*; (
	input  logic    clk_8,
	input  logic    pll_locked,
	input  dec_t    dec,
	input  logic    br,
	input  logic    turbo,
	input  logic    clr_berr,
	output logic    dtack,
	output logic    berr,
	output logic    ram_oe,
	output logic    ram_we,
	output io_sel_t io_sel,
	output ack_t    iack_ack
);

	logic [1:0] bus_cycle;
	logic [1:0] cyc_next;
	logic       cpu_slot;
	logic       grant;
	logic       oe_d;
	logic       we_d;
	logic       ack_d;
	logic       dtack_d;
	io_sel_t    io_d;
	logic       ack_q;
	logic [2:0] level_q;
	logic [3:0] tmo;

	// four slot bus cycle, slot 0 belongs to video
	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			bus_cycle <= 2'd0;
		end else begin
			bus_cycle <= cyc_next;
		end
	end

	// outputs are registered, so judge the slot they will appear in
	assign cyc_next = bus_cycle + 2'd1;
	// turbo adds slot 3 as a second cpu slot
	assign cpu_slot = (cyc_next == 2'd1) || (turbo && (cyc_next == 2'd3));
	// another bus master halts the cpu by holding off dtack
	assign grant    = cpu_slot && dec.valid && !br;

	always_comb begin
		// rom reads go through the ram port as well
		oe_d    = grant && dec.rw && (dec.ram_hit || dec.rom_hit);
		we_d    = grant && !dec.rw && dec.ram_hit;
		io_d    = grant ? dec.io : '0;
		// levels 2 and 4 are autovectored, level 6 is the mfp's own
		ack_d   = grant && dec.iack && (dec.iack_level inside {3'd2, 3'd4, 3'd6});
		dtack_d = oe_d || we_d || (|io_d) || ack_d;
	end

	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			dtack  <= 1'b0;
			ram_oe <= 1'b0;
			ram_we <= 1'b0;
			io_sel <= '0;
			ack_q  <= 1'b0;
		end else begin
			dtack  <= dtack_d;
			ram_oe <= oe_d;
			ram_we <= we_d;
			io_sel <= io_d;
			ack_q  <= ack_d;
		end
	end

	always_ff @(posedge clk_8) begin
		level_q <= dec.iack_level;
	end

	assign iack_ack = '{ack: ack_q, level: level_q};

	// dtack timeout, only cpu slots with a pending request count
	// once at the limit it holds until the core clears it
	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			tmo <= 4'd0;
		end else if (clr_berr) begin
			tmo <= 4'd0;
		end else if ((tmo != berr_limit) && cpu_slot && dec.valid) begin
			if (dtack_d) begin
				tmo <= 4'd0;
			end else if (!br) begin
				tmo <= tmo + 4'd1;
			end
		end
	end

	assign berr = (tmo == berr_limit);

	a_oe_we_excl: assert property (@(posedge clk_8) disable iff (!pll_locked)
		!(ram_oe && ram_we))
		else $error("bus_slot_ctrl: ram read and write together");

	// a bus request seen at one edge blocks dtack from the next edge on
	a_br_no_dtack: assert property (@(posedge clk_8) disable iff (!pll_locked)
		br |=> !dtack)
		else $error("bus_slot_ctrl: dtack while another master holds the bus");

endmodule

//--- irq_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// hbi vbi interrupt control
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module irq_ctrl import st_bus_pkg::*; (
	input  logic       clk_8,
	input  logic       pll_locked,
	input  logic       st_hs,
	input  logic       st_vs,
	input  logic       mfp_irq,
	input  ack_t       iack_ack,
	output logic [2:0] ipl,
	output logic [7:0] vector
);

	logic vs_q;
	logic vs_q2;
	logic hs_q;
	logic hs_q2;
	logic vbi;
	logic hbi;
	logic vbi_ack;
	logic hbi_ack;

	// vbi is level 4, hbi is level 2
	assign vbi_ack = iack_ack.ack && (iack_ack.level == 3'd4);
	assign hbi_ack = iack_ack.ack && (iack_ack.level == 3'd2);

	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			vs_q  <= 1'b0;
			vs_q2 <= 1'b0;
			hs_q  <= 1'b0;
			hs_q2 <= 1'b0;
			vbi   <= 1'b0;
			hbi   <= 1'b0;
		end else begin
			// syncs come from the video timing, register before use
			vs_q  <= st_vs;
			vs_q2 <= vs_q;
			hs_q  <= st_hs;
			hs_q2 <= hs_q;
			// acknowledge wins over a new edge in the same cycle
			if (vbi_ack) begin
				vbi <= 1'b0;
			end else if (vs_q && !vs_q2) begin
				vbi <= 1'b1;
			end
			if (hbi_ack) begin
				hbi <= 1'b0;
			end else if (hs_q && !hs_q2) begin
				hbi <= 1'b1;
			end
		end
	end

	// mfp above vbi above hbi
	assign ipl = mfp_irq ? ipl_mfp : (vbi ? ipl_vbi : (hbi ? ipl_hbi : ipl_idle));

	// vector only while the acknowledge is on the bus
	assign vector = vbi_ack ? vec_vbi : (hbi_ack ? vec_hbi : 8'h00);

endmodule

//--- st_bus_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// st cpu bus glue top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module st_bus_top import st_bus_pkg::*; (
	input  logic       clk_8,
	input  logic       pll_locked,
	input  logic       as,
	input  logic       rw,
	input  logic       uds,
	input  logic       lds,
	input  logic [2:0] fc,
	input  cpu_addr_u  addr,
	input  logic       br,
	input  logic       turbo,
	input  logic       blitter_en,
	input  logic [2:0] mem_cfg,
	input  logic       clr_berr,
	input  logic       st_hs,
	input  logic       st_vs,
	input  logic       mfp_irq,
	output logic       dtack,
	output logic       berr,
	output logic       ram_oe,
	output logic       ram_we,
	output io_sel_t    io_sel,
	output logic [2:0] ipl,
	output logic [7:0] vector
);

	cpu_req_t req;
	dec_t     dec;
	ack_t     iack_ack;

	// stage one, sample the cpu bus
	cpu_req_latch i_req (
		.clk_8      (clk_8),
		.pll_locked (pll_locked),
		.as         (as),
		.rw         (rw),
		.uds        (uds),
		.lds        (lds),
		.fc         (fc),
		.addr       (addr),
		.req        (req)
	);

	// stage two, memory and io map
	addr_decode i_dec (
		.clk_8      (clk_8),
		.pll_locked (pll_locked),
		.req        (req),
		.mem_cfg    (mem_cfg),
		.blitter_en (blitter_en),
		.dec        (dec)
	);

	// stage three, slot grant, strobes and timeout
	bus_slot_ctrl i_slot (
		.clk_8      (clk_8),
		.pll_locked (pll_locked),
		.dec        (dec),
		.br         (br),
		.turbo      (turbo),
		.clr_berr   (clr_berr),
		.dtack      (dtack),
		.berr       (berr),
		.ram_oe     (ram_oe),
		.ram_we     (ram_we),
		.io_sel     (io_sel),
		.iack_ack   (iack_ack)
	);

	irq_ctrl i_irq (
		.clk_8      (clk_8),
		.pll_locked (pll_locked),
		.st_hs      (st_hs),
		.st_vs      (st_vs),
		.mfp_irq    (mfp_irq),
		.iack_ack   (iack_ack),
		.ipl        (ipl),
		.vector     (vector)
	);

endmodule

//--- tb_st_bus.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// st bus glue testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_st_bus import st_bus_pkg::*; ();

	// expected decode of one request
	typedef struct packed {
		logic    ram;
		logic    rom;
		logic    iack;
		io_sel_t io;
	} map_t;

	logic       clk_8;
	logic       pll_locked;
	logic       as;
	logic       rw;
	logic       uds;
	logic       lds;
	logic [2:0] fc;
	cpu_addr_u  addr;
	logic       br;
	logic       turbo;
	logic       blitter_en;
	logic [2:0] mem_cfg;
	logic       clr_berr;
	logic       st_hs;
	logic       st_vs;
	logic       mfp_irq;
	logic       dtack;
	logic       berr;
	logic       ram_oe;
	logic       ram_we;
	io_sel_t    io_sel;
	logic [2:0] ipl;
	logic [7:0] vector;

	logic [15:0] lfsr_state;
	logic        aborted;
	int          error_count;
	int          test_errors;
	int          test_count;
	int          failed_tests;

	st_bus_top i_dut (
		.clk_8      (clk_8),
		.pll_locked (pll_locked),
		.as         (as),
		.rw         (rw),
		.uds        (uds),
		.lds        (lds),
		.fc         (fc),
		.addr       (addr),
		.br         (br),
		.turbo      (turbo),
		.blitter_en (blitter_en),
		.mem_cfg    (mem_cfg),
		.clr_berr   (clr_berr),
		.st_hs      (st_hs),
		.st_vs      (st_vs),
		.mfp_irq    (mfp_irq),
		.dtack      (dtack),
		.berr       (berr),
		.ram_oe     (ram_oe),
		.ram_we     (ram_we),
		.io_sel     (io_sel),
		.ipl        (ipl),
		.vector     (vector)
	);

	// 10 ns period stands in for the 8 MHz bus clock
	initial clk_8 = 1'b0;
	always #5 clk_8 = ~clk_8;

	// 16 bit fibonacci lfsr with taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		lfsr_step = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// one lfsr step per bit handed out
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// st memory map worked out on byte addresses
	function automatic map_t expected_map(input logic [22:0] wa, input logic rw_v,
			input logic [2:0] fc_v, input logic [2:0] cfg, input logic ben);
		logic [23:0] ba;
		logic [23:0] ram_top;
		logic [15:0] off;
		map_t        m;
		ba  = {wa, 1'b0};
		off = ba[15:0];
		m   = '0;
		// 8 MB and 14 MB extend the 4 MB base bank
		case (cfg)
			3'd4:    ram_top = 24'h800000;
			3'd5:    ram_top = 24'he00000;
			default: ram_top = 24'h400000;
		endcase
		if (fc_v == 3'd7) begin
			m.iack = 1'b1;
		end else begin
			// the reset vectors in the low 8 bytes come from rom
			m.ram = (ba >= 24'h000008) && (ba < ram_top);
			// tos 256k and then cartridge plus tos 192k as one block
			m.rom = rw_v && ((ba < 24'h000008)
				|| ((ba >= 24'he00000) && (ba < 24'he40000))
				|| ((ba >= 24'hfa0000) && (ba < 24'hff0000)));
			if (ba[23:16] == 8'hff) begin
				m.io.mmu     = (off >= 16'h8000) && (off < 16'h8002);
				m.io.vreg    = (off >= 16'h8200) && (off < 16'h8280);
				m.io.dma     = (off >= 16'h8600) && (off < 16'h8610);
				m.io.psg     = (off >= 16'h8800) && (off < 16'h8900);
				m.io.acia    = (off >= 16'hfc00) && (off < 16'hfd00);
				m.io.mfp     = (off >= 16'hfa00) && (off < 16'hfa40);
				m.io.blitter = ben && (off >= 16'h8a00) && (off < 16'h8b00);
			end
		end
		return m;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("Mismatch %s: expected %0h, actual %0h", name, expected, actual);
			error_count++;
			test_errors++;
		end
	endtask

	task automatic finish_test(input string name);
		test_count++;
		if (test_errors == 0) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: failed with %0d errors", name, test_errors);
			failed_tests++;
		end
		test_errors = 0;
	endtask

	// cpu starts a bus cycle and holds it
	task automatic present_req(input logic [22:0] wa, input logic rw_v, input logic [2:0] fc_v);
		@(posedge clk_8);
		as       <= 1'b1;
		rw       <= rw_v;
		uds      <= 1'b1;
		lds      <= 1'b1;
		fc       <= fc_v;
		addr.mem <= wa;
	endtask

	// end the cycle and let the three stages empty
	task automatic release_req();
		@(posedge clk_8);
		as <= 1'b0;
		rw <= 1'b1;
		fc <= 3'd0;
		repeat (4) @(posedge clk_8);
	endtask

	task automatic clear_berr();
		@(posedge clk_8);
		clr_berr <= 1'b1;
		@(posedge clk_8);
		clr_berr <= 1'b0;
	endtask

	// returns on dtack or bus error as seen on the falling edge
	task automatic wait_response(input string name, output logic got_dtack,
			output logic got_berr);
		int cycles;
		got_dtack = 1'b0;
		got_berr  = 1'b0;
		cycles    = 0;
		while (!aborted && !got_dtack && !got_berr && (cycles < 200)) begin
			@(negedge clk_8);
			got_dtack = dtack;
			got_berr  = berr;
			cycles++;
		end
		if (!aborted && !got_dtack && !got_berr) begin
			$display("timeout: %s got neither dtack nor a bus error", name);
			aborted = 1'b1;
			error_count++;
			test_errors++;
		end
	endtask

	task automatic wait_ipl(input string name, input logic [2:0] expected);
		int cycles;
		cycles = 0;
		@(negedge clk_8);
		while ((ipl !== expected) && (cycles < 16)) begin
			@(negedge clk_8);
			cycles++;
		end
		check_value(name, 32'(expected), 32'(ipl));
	endtask

	task automatic count_dtack(output int n);
		n = 0;
		repeat (8) begin
			@(negedge clk_8);
			if (dtack) begin
				n++;
			end
		end
	endtask

	// one request through the map and compared against expected_map
	task automatic map_request(input string name, input logic [22:0] wa, input logic rw_v,
			input logic [2:0] cfg, input logic ben);
		map_t exp;
		logic exp_dtack;
		logic got_dtack;
		logic got_berr;
		exp       = expected_map(wa, rw_v, 3'd5, cfg, ben);
		exp_dtack = (rw_v && (exp.ram || exp.rom)) || (!rw_v && exp.ram) || (|exp.io);
		present_req(wa, rw_v, 3'd5);
		mem_cfg    <= cfg;
		blitter_en <= ben;
		wait_response(name, got_dtack, got_berr);
		if (!aborted) begin
			check_value({name, " dtack"}, 32'(exp_dtack), 32'(got_dtack));
			check_value({name, " berr"}, 32'(!exp_dtack), 32'(got_berr));
			if (got_dtack) begin
				check_value({name, " ram_oe"}, 32'(rw_v && (exp.ram || exp.rom)), 32'(ram_oe));
				check_value({name, " ram_we"}, 32'(!rw_v && exp.ram), 32'(ram_we));
				check_value({name, " io_sel"}, 32'(exp.io), 32'(io_sel));
			end
		end
		release_req();
		if (got_berr) begin
			clear_berr();
		end
		finish_test(name);
	endtask

	task automatic ram_map_tests();
		logic [31:0] r;
		logic [22:0] wa;
		logic        rw_v;
		logic [2:0]  cfg;
		for (int i = 0; i < 16; i++) begin
			r  = rand_bits(23);
			wa = r[22:0];
			// about half land in the 4 MB base bank
			if (rand_bits(1) != 0) begin
				wa[22:21] = 2'b00;
			end
			r    = rand_bits(1);
			rw_v = r[0];
			r    = rand_bits(3) % 6;
			cfg  = r[2:0];
			if (!aborted) begin
				map_request($sformatf("ram_map_%0d", i), wa, rw_v, cfg, 1'b0);
			end
		end
	endtask

	task automatic io_map_tests();
		logic [31:0] r;
		logic [15:0] base;
		logic [15:0] off;
		logic        ben;
		int          span;
		for (int i = 0; i < 14; i++) begin
			r = rand_bits(3) % 7;
			case (r[2:0])
				3'd0: begin
					base = 16'h8000;
					span = 2;
				end
				3'd1: begin
					base = 16'h8200;
					span = 128;
				end
				3'd2: begin
					base = 16'h8600;
					span = 16;
				end
				3'd3: begin
					base = 16'h8800;
					span = 256;
				end
				3'd4: begin
					base = 16'hfc00;
					span = 256;
				end
				3'd5: begin
					base = 16'hfa00;
					span = 64;
				end
				default: begin
					base = 16'h8a00;
					span = 256;
				end
			endcase
			r   = rand_bits(8) % span;
			off = base + r[15:0];
			// now and then an offset anywhere in the page
			if ((i % 5) == 4) begin
				r   = rand_bits(16);
				off = r[15:0];
			end
			r   = rand_bits(1);
			ben = r[0];
			if (!aborted) begin
				map_request($sformatf("io_map_%0d", i), {8'hff, off[15:1]}, 1'b1, 3'd3, ben);
			end
		end
	endtask

	task automatic rom_write_berr();
		logic got_dtack;
		logic got_berr;
		// tos area at 0xe00100
		present_req(23'h700080, 1'b0, 3'd5);
		wait_response("rom_write", got_dtack, got_berr);
		check_value("rom_write dtack", 32'd0, 32'(got_dtack));
		check_value("rom_write berr", 32'd1, 32'(got_berr));
		clear_berr();
		@(negedge clk_8);
		check_value("rom_write berr cleared", 32'd0, 32'(berr));
		release_req();
		clear_berr();
		finish_test("rom_write_berr");
	endtask

	task automatic bus_request_hold();
		logic got_dtack;
		logic got_berr;
		int   strobes;
		@(posedge clk_8);
		br <= 1'b1;
		present_req(23'h001000, 1'b1, 3'd5);
		strobes = 0;
		repeat (40) begin
			@(negedge clk_8);
			if (dtack || ram_oe || ram_we) begin
				strobes++;
			end
		end
		check_value("br_hold strobes", 32'd0, 32'(strobes));
		@(posedge clk_8);
		br <= 1'b0;
		wait_response("br_release", got_dtack, got_berr);
		check_value("br_release dtack", 32'd1, 32'(got_dtack));
		release_req();
		finish_test("bus_request_hold");
	endtask

	task automatic interrupt_sequence();
		map_t exp;
		logic got_dtack;
		logic got_berr;
		@(posedge clk_8);
		st_vs <= 1'b1;
		wait_ipl("irq vbi pending", 3'b011);
		// iack cycle with the level in address bits 3:1
		// levels 4 and 2 are autovectored so the glue answers them itself
		exp = expected_map({20'hfffff, 3'd4}, 1'b1, 3'd7, mem_cfg, blitter_en);
		present_req({20'hfffff, 3'd4}, 1'b1, 3'd7);
		wait_response("irq vbi ack", got_dtack, got_berr);
		check_value("irq vbi dtack", 32'(exp.iack), 32'(got_dtack));
		check_value("irq vbi io_sel", 32'(exp.io), 32'(io_sel));
		check_value("irq vbi vector", 32'h1c, 32'(vector));
		release_req();
		wait_ipl("irq vbi cleared", 3'b111);
		@(posedge clk_8);
		st_vs   <= 1'b0;
		st_hs   <= 1'b1;
		mfp_irq <= 1'b1;
		// give the hbi flag time to set under the mfp
		repeat (4) @(posedge clk_8);
		wait_ipl("irq mfp over hbi", 3'b001);
		@(posedge clk_8);
		mfp_irq <= 1'b0;
		wait_ipl("irq hbi pending", 3'b101);
		exp = expected_map({20'hfffff, 3'd2}, 1'b1, 3'd7, mem_cfg, blitter_en);
		present_req({20'hfffff, 3'd2}, 1'b1, 3'd7);
		wait_response("irq hbi ack", got_dtack, got_berr);
		check_value("irq hbi dtack", 32'(exp.iack), 32'(got_dtack));
		check_value("irq hbi io_sel", 32'(exp.io), 32'(io_sel));
		check_value("irq hbi vector", 32'h1a, 32'(vector));
		release_req();
		wait_ipl("irq hbi cleared", 3'b111);
		@(posedge clk_8);
		st_hs <= 1'b0;
		finish_test("interrupt_sequence");
	endtask

	task automatic slot_rate();
		logic got_dtack;
		logic got_berr;
		int   n;
		present_req(23'h000800, 1'b1, 3'd5);
		wait_response("slot_rate", got_dtack, got_berr);
		count_dtack(n);
		check_value("slot_rate normal", 32'd2, 32'(n));
		@(posedge clk_8);
		turbo <= 1'b1;
		repeat (2) @(negedge clk_8);
		count_dtack(n);
		check_value("slot_rate turbo", 32'd4, 32'(n));
		@(posedge clk_8);
		turbo <= 1'b0;
		release_req();
		finish_test("slot_rate");
	endtask

	task automatic reset_state();
		@(negedge clk_8);
		check_value("reset dtack", 32'd0, 32'(dtack));
		check_value("reset berr", 32'd0, 32'(berr));
		check_value("reset ram_oe", 32'd0, 32'(ram_oe));
		check_value("reset ram_we", 32'd0, 32'(ram_we));
		check_value("reset io_sel", 32'd0, 32'(io_sel));
		check_value("reset iack ack", 32'd0, 32'(i_dut.iack_ack.ack));
		check_value("reset ipl", 32'd7, 32'(ipl));
		check_value("reset vector", 32'd0, 32'(vector));
		finish_test("reset_state");
	endtask

	initial begin
		pll_locked   <= 1'b0;
		as           <= 1'b0;
		rw           <= 1'b1;
		uds          <= 1'b0;
		lds          <= 1'b0;
		fc           <= 3'd0;
		addr         <= '0;
		br           <= 1'b0;
		turbo        <= 1'b0;
		blitter_en   <= 1'b0;
		mem_cfg      <= 3'd3;
		clr_berr     <= 1'b0;
		st_hs        <= 1'b0;
		st_vs        <= 1'b0;
		mfp_irq      <= 1'b0;
		lfsr_state   = 16'd56;
		aborted      = 1'b0;
		error_count  = 0;
		test_errors  = 0;
		test_count   = 0;
		failed_tests = 0;
		// 8 cycles in reset
		repeat (8) @(posedge clk_8);
		pll_locked <= 1'b1;
		reset_state();
		ram_map_tests();
		if (!aborted) begin
			io_map_tests();
		end
		if (!aborted) begin
			rom_write_berr();
		end
		if (!aborted) begin
			bus_request_hold();
		end
		if (!aborted) begin
			interrupt_sequence();
		end
		if (!aborted) begin
			slot_rate();
		end
		$display("%0d tests, %0d failed, %0d check errors", test_count, failed_tests,
			error_count);
		if (error_count == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

//--- all.f
st_bus_pkg.sv
cpu_req_latch.sv
addr_decode.sv
bus_slot_ctrl.sv
irq_ctrl.sv
st_bus_top.sv
tb_st_bus.sv

//--- run_sim.sh
#!/bin/sh
# build the st bus testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_st_bus -Mdir obj_dir -f all.f
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/Vtb_st_bus > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

# the log decides the result
if grep -q -F '*** PASSED ***' sim.log; then
	exit 0
else
	echo "pass message not found in sim.log"
	exit 1
fi
